// ==== verilog/rtf65000_cfg.svh ====
`ifndef RTF65000_CFG_SVH
`define RTF65000_CFG_SVH

// depth of the prefetch queue in words. The pointer math assumes a power of two.
`define QUEUE_WORDS 8

// source effective address fields of the opcode word.
`define M   5:3
`define Xn  2:0

// destination effective address fields of a MOVE.
`define DM  8:6
`define DXn 11:9

`endif

// ==== verilog/rtf65000_pkg.sv ====
`include "rtf65000_cfg.svh"

package rtf65000_pkg;

	typedef logic [15:0] iword_t;

	// head word in the low sixteen bits, later words above it.
	typedef logic [79:0] iwin_t;

	// instruction length in words, 1 to 5.
	typedef logic [2:0] ilen_t;

	typedef logic [$clog2(`QUEUE_WORDS + 1) - 1:0] qcount_t;

	typedef enum logic [6:0] {
		op_illegal,
		op_ori_sr, op_ori, op_andi_sr, op_andi,
		op_subi, op_addi, op_eori_sr, op_eori, op_cmpi,
		op_btst, op_bchg, op_bclr, op_bset,
		op_move, op_movea, op_move_from_sr, op_move_to_sr,
		op_negx, op_clr, op_neg, op_not,
		op_ext, op_nbcd, op_swap, op_pea,
		op_tas, op_tst, op_trap, op_link, op_unlk,
		op_reset, op_nop, op_stop, op_rte, op_rts, op_trapv,
		op_jsr, op_jmp, op_lea, op_chk,
		op_addq, op_subq, op_scc, op_dbcc,
		op_bra, op_bsr, op_bcc, op_moveq,
		op_divu, op_divs, op_sbcd, op_or,
		op_sub, op_subx, op_suba,
		op_eor, op_cmp, op_cmpa,
		op_mulu, op_muls, op_abcd, op_exg, op_and,
		op_add, op_addx, op_adda,
		// memory shifts by one bit.
		op_asdm, op_lsdm, op_roxdm, op_rodm,
		// register shifts.
		op_asd, op_lsd, op_roxd, op_rod
	} op_t;

endpackage

// ==== verilog/idecoder.sv ====
`timescale 1ns/1ps
`include "rtf65000_cfg.svh"

module idecoder (
	input  rtf65000_pkg::iword_t opcode,
	output rtf65000_pkg::op_t    op
);

	// the opcode line selects a group, then the subfields pick the mnemonic.
	// within a line, the more specific pattern is tested first.
	always_comb begin
		op = rtf65000_pkg::op_illegal;
		case (opcode[15:12])
			4'h0: begin
				if (opcode == 16'h007C)
					op = rtf65000_pkg::op_ori_sr;
				else if (opcode[11:8] == 4'h0)
					op = rtf65000_pkg::op_ori;
				else if (opcode == 16'h027C)
					op = rtf65000_pkg::op_andi_sr;
				else if (opcode[11:8] == 4'h2)
					op = rtf65000_pkg::op_andi;
				else if (opcode[11:8] == 4'h4)
					op = rtf65000_pkg::op_subi;
				else if (opcode[11:8] == 4'h6)
					op = rtf65000_pkg::op_addi;
				else if (opcode == 16'h0A7C)
					op = rtf65000_pkg::op_eori_sr;
				else if (opcode[11:8] == 4'hA)
					op = rtf65000_pkg::op_eori;
				else if (opcode[11:8] == 4'hC)
					op = rtf65000_pkg::op_cmpi;
				else if (opcode[11:6] == 6'b1000_00)
					op = rtf65000_pkg::op_btst;
				else if (opcode[11:6] == 6'b1000_01)
					op = rtf65000_pkg::op_bchg;
				else if (opcode[11:6] == 6'b1000_10)
					op = rtf65000_pkg::op_bclr;
				else if (opcode[11:6] == 6'b1000_11)
					op = rtf65000_pkg::op_bset;
			end
			4'h1, 4'h2, 4'h3: begin
				if (opcode[`DM] == 3'b001)
					op = rtf65000_pkg::op_movea;
				else
					op = rtf65000_pkg::op_move;
			end
			4'h4: begin
				if (opcode == 16'h4AFC)
					op = rtf65000_pkg::op_illegal;
				else if (opcode[11:6] == 6'b0000_11)
					op = rtf65000_pkg::op_move_from_sr;
				else if (opcode[11:8] == 4'h0)
					op = rtf65000_pkg::op_negx;
				else if (opcode[11:8] == 4'h2)
					op = rtf65000_pkg::op_clr;
				else if (opcode[11:8] == 4'h4)
					op = rtf65000_pkg::op_neg;
				else if (opcode[11:6] == 6'b0110_11)
					op = rtf65000_pkg::op_move_to_sr;
				else if (opcode[11:8] == 4'h6)
					op = rtf65000_pkg::op_not;
				else if (opcode[11:8] == 4'h8 && opcode[7] && opcode[5:3] == 3'b000)
					op = rtf65000_pkg::op_ext;
				else if (opcode[11:6] == 6'b1000_00)
					op = rtf65000_pkg::op_nbcd;
				else if (opcode[11:3] == 9'b1000_0100_0)
					op = rtf65000_pkg::op_swap;
				else if (opcode[11:6] == 6'b1000_01)
					op = rtf65000_pkg::op_pea;
				else if (opcode[11:6] == 6'b1010_11)
					op = rtf65000_pkg::op_tas;
				else if (opcode[11:8] == 4'hA)
					op = rtf65000_pkg::op_tst;
				else if (opcode[11:4] == 8'hE4)
					op = rtf65000_pkg::op_trap;
				else if (opcode[11:3] == 9'b1110_0101_0)
					op = rtf65000_pkg::op_link;
				else if (opcode[11:3] == 9'b1110_0101_1)
					op = rtf65000_pkg::op_unlk;
				else if (opcode == 16'h4E70)
					op = rtf65000_pkg::op_reset;
				else if (opcode == 16'h4E71)
					op = rtf65000_pkg::op_nop;
				else if (opcode == 16'h4E72)
					op = rtf65000_pkg::op_stop;
				else if (opcode == 16'h4E73)
					op = rtf65000_pkg::op_rte;
				else if (opcode == 16'h4E75)
					op = rtf65000_pkg::op_rts;
				else if (opcode == 16'h4E76)
					op = rtf65000_pkg::op_trapv;
				else if (opcode[11:6] == 6'b1110_10)
					op = rtf65000_pkg::op_jsr;
				else if (opcode[11:6] == 6'b1110_11)
					op = rtf65000_pkg::op_jmp;
				else if (opcode[8:6] == 3'b111)
					op = rtf65000_pkg::op_lea;
				else if (opcode[8:6] == 3'b110)
					op = rtf65000_pkg::op_chk;
			end
			4'h5: begin
				if (opcode[7:3] == 5'b11001)
					op = rtf65000_pkg::op_dbcc;
				else if (opcode[7:6] == 2'b11)
					op = rtf65000_pkg::op_scc;
				else if (!opcode[8])
					op = rtf65000_pkg::op_addq;
				else
					op = rtf65000_pkg::op_subq;
			end
			4'h6: begin
				if (opcode[11:8] == 4'h0)
					op = rtf65000_pkg::op_bra;
				else if (opcode[11:8] == 4'h1)
					op = rtf65000_pkg::op_bsr;
				else
					op = rtf65000_pkg::op_bcc;
			end
			4'h7: begin
				if (!opcode[8])
					op = rtf65000_pkg::op_moveq;
			end
			4'h8: begin
				if (opcode[8:6] == 3'b011)
					op = rtf65000_pkg::op_divu;
				else if (opcode[8:6] == 3'b111)
					op = rtf65000_pkg::op_divs;
				else if (opcode[8:4] == 5'b10000)
					op = rtf65000_pkg::op_sbcd;
				else
					op = rtf65000_pkg::op_or;
			end
			4'h9: begin
				// size 11 marks SUBA, so it wins over the SUBX register forms.
				if (opcode[7:6] == 2'b11)
					op = rtf65000_pkg::op_suba;
				else if (opcode[8] && opcode[5:4] == 2'b00)
					op = rtf65000_pkg::op_subx;
				else
					op = rtf65000_pkg::op_sub;
			end
			4'hB: begin
				if (opcode[7:6] == 2'b11)
					op = rtf65000_pkg::op_cmpa;
				else if (opcode[8])
					op = rtf65000_pkg::op_eor;
				else
					op = rtf65000_pkg::op_cmp;
			end
			4'hC: begin
				// only the three real EXG opmodes, so ABCD and MULS stay reachable.
				if (opcode[8] && (opcode[7:3] == 5'b01000 || opcode[7:3] == 5'b01001
						|| opcode[7:3] == 5'b10001))
					op = rtf65000_pkg::op_exg;
				else if (opcode[8:6] == 3'b111)
					op = rtf65000_pkg::op_muls;
				else if (opcode[8:6] == 3'b011)
					op = rtf65000_pkg::op_mulu;
				else if (opcode[8:4] == 5'b10000)
					op = rtf65000_pkg::op_abcd;
				else
					op = rtf65000_pkg::op_and;
			end
			4'hD: begin
				if (opcode[7:6] == 2'b11)
					op = rtf65000_pkg::op_adda;
				else if (opcode[8] && opcode[5:4] == 2'b00)
					op = rtf65000_pkg::op_addx;
				else
					op = rtf65000_pkg::op_add;
			end
			4'hE: begin
				if (opcode[7:6] == 2'b11 && !opcode[11]) begin
					case (opcode[10:9])
						2'b00: op = rtf65000_pkg::op_asdm;
						2'b01: op = rtf65000_pkg::op_lsdm;
						2'b10: op = rtf65000_pkg::op_roxdm;
						default: op = rtf65000_pkg::op_rodm;
					endcase
				end else if (opcode[7:6] != 2'b11) begin
					case (opcode[4:3])
						2'b00: op = rtf65000_pkg::op_asd;
						2'b01: op = rtf65000_pkg::op_lsd;
						2'b10: op = rtf65000_pkg::op_roxd;
						default: op = rtf65000_pkg::op_rod;
					endcase
				end
			end
			default: op = rtf65000_pkg::op_illegal;
		endcase
	end

endmodule

// ==== verilog/ilength.sv ====
`timescale 1ns/1ps
`include "rtf65000_cfg.svh"

module ilength (
	input  rtf65000_pkg::op_t    op,
	input  rtf65000_pkg::iword_t opcode,
	input  logic [7:0]           disp8,
	output rtf65000_pkg::ilen_t  len
);

	logic       is_mr;
	logic       is_imm;
	logic [1:0] imm_words;
	logic [1:0] src_words;
	logic [1:0] dst_words;
	logic [1:0] br_words;

	// extension words taken by one effective address.
	// the immediate mode is counted as a single word whatever the size.
	function automatic logic [1:0] ea_words(input logic [2:0] mode, input logic [2:0] rn);
		logic [1:0] n;
		n = 2'd0;
		if (mode == 3'b101 || mode == 3'b110)
			n = 2'd1;
		else if (mode == 3'b111) begin
			case (rn)
				3'b000, 3'b010, 3'b011, 3'b100: n = 2'd1;
				3'b001: n = 2'd2;
				default: n = 2'd0;
			endcase
		end
		return n;
	endfunction

	always_comb begin
		case (op)
			rtf65000_pkg::op_ori, rtf65000_pkg::op_andi, rtf65000_pkg::op_subi,
			rtf65000_pkg::op_addi, rtf65000_pkg::op_eori, rtf65000_pkg::op_cmpi:
				is_imm = 1'b1;
			default: is_imm = 1'b0;
		endcase
	end

	always_comb begin
		case (op)
			rtf65000_pkg::op_ori, rtf65000_pkg::op_andi, rtf65000_pkg::op_subi,
			rtf65000_pkg::op_addi, rtf65000_pkg::op_eori, rtf65000_pkg::op_cmpi,
			rtf65000_pkg::op_btst, rtf65000_pkg::op_bchg, rtf65000_pkg::op_bclr,
			rtf65000_pkg::op_bset, rtf65000_pkg::op_move, rtf65000_pkg::op_movea,
			rtf65000_pkg::op_move_from_sr, rtf65000_pkg::op_move_to_sr,
			rtf65000_pkg::op_negx, rtf65000_pkg::op_clr, rtf65000_pkg::op_neg,
			rtf65000_pkg::op_not, rtf65000_pkg::op_nbcd, rtf65000_pkg::op_pea,
			rtf65000_pkg::op_tas, rtf65000_pkg::op_tst, rtf65000_pkg::op_jsr,
			rtf65000_pkg::op_jmp, rtf65000_pkg::op_lea, rtf65000_pkg::op_chk,
			rtf65000_pkg::op_addq, rtf65000_pkg::op_subq, rtf65000_pkg::op_scc,
			rtf65000_pkg::op_divu, rtf65000_pkg::op_divs, rtf65000_pkg::op_or,
			rtf65000_pkg::op_sub, rtf65000_pkg::op_suba, rtf65000_pkg::op_eor,
			rtf65000_pkg::op_cmp, rtf65000_pkg::op_cmpa, rtf65000_pkg::op_mulu,
			rtf65000_pkg::op_muls, rtf65000_pkg::op_and, rtf65000_pkg::op_add,
			rtf65000_pkg::op_adda, rtf65000_pkg::op_asdm, rtf65000_pkg::op_lsdm,
			rtf65000_pkg::op_roxdm, rtf65000_pkg::op_rodm:
				is_mr = 1'b1;
			default: is_mr = 1'b0;
		endcase
	end

	always_comb begin
		imm_words = 2'd0;
		if (op == rtf65000_pkg::op_ori_sr || op == rtf65000_pkg::op_andi_sr
				|| op == rtf65000_pkg::op_eori_sr || op == rtf65000_pkg::op_stop
				|| op == rtf65000_pkg::op_link)
			imm_words = 2'd1;
		else if (is_imm)
			imm_words = opcode[7] ? 2'd2 : 2'd1;
	end

	assign src_words = is_mr ? ea_words(opcode[`M], opcode[`Xn]) : 2'd0;
	assign dst_words = (op == rtf65000_pkg::op_move || op == rtf65000_pkg::op_movea) ?
		ea_words(opcode[`DM], opcode[`DXn]) : 2'd0;

	always_comb begin
		br_words = 2'd0;
		if (op == rtf65000_pkg::op_bra || op == rtf65000_pkg::op_bsr
				|| op == rtf65000_pkg::op_bcc) begin
			if (disp8 == 8'h00)
				br_words = 2'd1;
			else if (disp8 == 8'hFF)
				br_words = 2'd2;
		end else if (op == rtf65000_pkg::op_dbcc)
			br_words = 2'd1;
	end

	// no instruction combines more than four extension words.
	assign len = rtf65000_pkg::ilen_t'(3'd1 + imm_words + src_words + dst_words + br_words);

endmodule

// ==== verilog/iqueue.sv ====
`timescale 1ns/1ps
`include "rtf65000_cfg.svh"

module iqueue (
	input  logic                  clk,
	input  logic                  rst_n,
	input  rtf65000_pkg::iword_t  word,
	input  logic                  word_strobe,
	input  logic                  consume,
	input  rtf65000_pkg::ilen_t   consume_len,
	output rtf65000_pkg::iwin_t   window,
	output rtf65000_pkg::qcount_t count,
	output logic                  full
);

	localparam int PW = $clog2(`QUEUE_WORDS);

	rtf65000_pkg::iword_t mem [`QUEUE_WORDS];
	logic [PW-1:0]        rd_ptr;
	logic [PW-1:0]        wr_ptr;
	logic                 wr_en;
	logic [PW-1:0]        rd_step;

	assign full = (count == rtf65000_pkg::qcount_t'(`QUEUE_WORDS));

	// a strobe while full is lost.
	assign wr_en = word_strobe && !full;
	assign rd_step = consume ? PW'(consume_len) : '0;

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= word;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			rd_ptr <= rd_ptr + rd_step;
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			count <= count + rtf65000_pkg::qcount_t'(wr_en)
				- (consume ? rtf65000_pkg::qcount_t'(consume_len) : '0);
		end
	end

	// five words from the head, zero past the occupied part.
	always_comb begin
		logic [PW-1:0] idx;
		window = '0;
		for (int i = 0; i < 5; i++) begin
			idx = rd_ptr + PW'(i);
			if (rtf65000_pkg::qcount_t'(i) < count)
				window[16*i +: 16] = mem[idx];
		end
	end

endmodule

// ==== verilog/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
	input  logic                 clk,
	input  logic                 rst_n,
	input  rtf65000_pkg::iword_t word,
	input  logic                 word_strobe,
	input  logic                 hold,
	output logic                 full,
	output logic                 dec_valid,
	output rtf65000_pkg::op_t    dec_op,
	output rtf65000_pkg::ilen_t  dec_len,
	output rtf65000_pkg::iwin_t  dec_window
);

	rtf65000_pkg::iwin_t   window;
	rtf65000_pkg::qcount_t count;
	rtf65000_pkg::op_t     op;
	rtf65000_pkg::ilen_t   len;
	logic                  ready;

	iqueue iqueue_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.word        (word),
		.word_strobe (word_strobe),
		.consume     (ready),
		.consume_len (len),
		.window      (window),
		.count       (count),
		.full        (full)
	);

	idecoder idecoder_inst (
		.opcode (window[15:0]),
		.op     (op)
	);

	ilength ilength_inst (
		.op     (op),
		.opcode (window[15:0]),
		.disp8  (window[7:0]),
		.len    (len)
	);

	// the head instruction is complete once every one of its words is queued.
	assign ready = (count >= rtf65000_pkg::qcount_t'(len)) && !hold;

	always_ff @(posedge clk) begin
		if (!rst_n)
			dec_valid <= 1'b0;
		else
			dec_valid <= ready;
	end

	always_ff @(posedge clk) begin
		if (ready) begin
			dec_op <= op;
			dec_len <= len;
			dec_window <= window;
		end
	end

endmodule

// ==== test/decode_unit_chk.sv ====
`timescale 1ns/1ps
`include "rtf65000_cfg.svh"

module decode_unit_chk (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  word_strobe,
	input logic                  hold,
	input logic                  full,
	input rtf65000_pkg::qcount_t count,
	input logic                  dec_valid,
	input rtf65000_pkg::ilen_t   dec_len
);

	int fail_count = 0;

	// a word strobed into a full queue is dropped and the stream falls out of step.
	strobe_when_full: assert property (@(posedge clk) disable iff (!rst_n)
		!(word_strobe && full))
		else begin
			fail_count++;
			$error("word strobe while the queue is full");
		end

	occupancy_limit: assert property (@(posedge clk) disable iff (!rst_n)
		count <= rtf65000_pkg::qcount_t'(`QUEUE_WORDS))
		else begin
			fail_count++;
			$error("queue count above its depth");
		end

	// hold seen on an edge blocks the issue that dec_valid would show after it.
	issue_under_hold: assert property (@(posedge clk) disable iff (!rst_n)
		hold |=> !dec_valid)
		else begin
			fail_count++;
			$error("instruction issued while hold was high");
		end

	len_range: assert property (@(posedge clk) disable iff (!rst_n)
		dec_valid |-> (dec_len >= 3'd1 && dec_len <= 3'd5))
		else begin
			fail_count++;
			$error("issued length outside 1 to 5 words");
		end

endmodule

// ==== test/decode_unit_tb.sv ====
`timescale 1ns/1ps
`include "rtf65000_cfg.svh"

module decode_unit_tb;

	logic                 clk;
	logic                 rst_n;
	rtf65000_pkg::iword_t word;
	logic                 word_strobe;
	logic                 hold;
	logic                 full;
	logic                 dec_valid;
	rtf65000_pkg::op_t    dec_op;
	rtf65000_pkg::ilen_t  dec_len;
	rtf65000_pkg::iwin_t  dec_window;

	// one row per instruction, the words packed with the head word lowest.
	rtf65000_pkg::op_t   row_op[$];
	rtf65000_pkg::ilen_t row_len[$];
	int                  row_n[$];
	rtf65000_pkg::iwin_t row_win[$];

	rtf65000_pkg::op_t   got_op[$];
	rtf65000_pkg::ilen_t got_len[$];
	rtf65000_pkg::iwin_t got_win[$];

	int          errors;
	int          tests;
	int          failed;
	int          issued;
	int          bp_first;
	int          e0;
	logic        ok;
	logic [31:0] lfsr;

	decode_unit decode_unit_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.word        (word),
		.word_strobe (word_strobe),
		.hold        (hold),
		.full        (full),
		.dec_valid   (dec_valid),
		.dec_op      (dec_op),
		.dec_len     (dec_len),
		.dec_window  (dec_window)
	);

	bind decode_unit decode_unit_chk decode_unit_chk_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.word_strobe (word_strobe),
		.hold        (hold),
		.full        (full),
		.count       (count),
		.dec_valid   (dec_valid),
		.dec_len     (dec_len)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// outputs are registered, so the falling edge sees them settled.
	always @(negedge clk) begin
		if (rst_n && dec_valid === 1'b1) begin
			got_op.push_back(dec_op);
			got_len.push_back(dec_len);
			got_win.push_back(dec_window);
			issued++;
		end
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
	endfunction

	task automatic step();
		@(posedge clk);
		#2;
	endtask

	task automatic random_gap();
		int gap;
		gap = 0;
		for (int b = 0; b < 2; b++) begin
			lfsr = lfsr_step(lfsr);
			gap = gap * 2 + int'(lfsr[0]);
		end
		repeat (gap) step();
	endtask

	task automatic check_op(input string name, input rtf65000_pkg::op_t got,
			input rtf65000_pkg::op_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED t=%0t %s got=%s exp=%s", $time, name, got.name(), exp.name());
			errors++;
		end
	endtask

	task automatic check_len(input string name, input rtf65000_pkg::ilen_t got,
			input rtf65000_pkg::ilen_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_word(input string name, input rtf65000_pkg::iword_t got,
			input rtf65000_pkg::iword_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED t=%0t %s got=%b exp=%b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		if (errors == err_before) begin
			$display("test %s ok", name);
		end else begin
			failed++;
			$display("test %s failed", name);
		end
	endtask

	task automatic add_row(input rtf65000_pkg::op_t op, input rtf65000_pkg::ilen_t len,
			input int n, input rtf65000_pkg::iword_t w0, input rtf65000_pkg::iword_t w1 = 16'h0,
			input rtf65000_pkg::iword_t w2 = 16'h0, input rtf65000_pkg::iword_t w3 = 16'h0,
			input rtf65000_pkg::iword_t w4 = 16'h0);
		row_op.push_back(op);
		row_len.push_back(len);
		row_n.push_back(n);
		row_win.push_back({w4, w3, w2, w1, w0});
	endtask

	task automatic build_table();
		add_row(rtf65000_pkg::op_ori_sr, 3'd2, 2, 16'h007C, 16'h1234);
		add_row(rtf65000_pkg::op_ori, 3'd2, 2, 16'h0000, 16'h00AB);
		add_row(rtf65000_pkg::op_andi, 3'd3, 3, 16'h0281, 16'hDEAD, 16'hBEEF);
		add_row(rtf65000_pkg::op_andi_sr, 3'd2, 2, 16'h027C, 16'h00FF);
		add_row(rtf65000_pkg::op_cmpi, 3'd4, 4, 16'h0C79, 16'h0005, 16'h0001, 16'h2000);
		add_row(rtf65000_pkg::op_addi, 3'd4, 4, 16'h06A8, 16'h0000, 16'h0010, 16'h0004);
		add_row(rtf65000_pkg::op_bset, 3'd2, 2, 16'h08F8, 16'h1000);
		add_row(rtf65000_pkg::op_move, 3'd1, 1, 16'h1200);
		add_row(rtf65000_pkg::op_move, 3'd3, 3, 16'h2368, 16'h0004, 16'h0008);
		add_row(rtf65000_pkg::op_movea, 3'd1, 1, 16'h3240);
		add_row(rtf65000_pkg::op_illegal, 3'd1, 1, 16'h4AFC);
		add_row(rtf65000_pkg::op_tas, 3'd1, 1, 16'h4AC0);
		add_row(rtf65000_pkg::op_tst, 3'd2, 2, 16'h4A6A, 16'h0008);
		add_row(rtf65000_pkg::op_move_to_sr, 3'd2, 2, 16'h46FC, 16'h2700);
		add_row(rtf65000_pkg::op_link, 3'd2, 2, 16'h4E56, 16'hFFF8);
		add_row(rtf65000_pkg::op_stop, 3'd2, 2, 16'h4E72, 16'h2000);
		add_row(rtf65000_pkg::op_lea, 3'd2, 2, 16'h41FA, 16'h0010);
		add_row(rtf65000_pkg::op_dbcc, 3'd2, 2, 16'h51C8, 16'hFFFE);
		add_row(rtf65000_pkg::op_scc, 3'd1, 1, 16'h57C0);
		add_row(rtf65000_pkg::op_addq, 3'd2, 2, 16'h52A8, 16'h0004);
		add_row(rtf65000_pkg::op_subq, 3'd1, 1, 16'h5340);
		add_row(rtf65000_pkg::op_bra, 3'd1, 1, 16'h6010);
		add_row(rtf65000_pkg::op_bsr, 3'd2, 2, 16'h6100, 16'h0100);
		add_row(rtf65000_pkg::op_bcc, 3'd3, 3, 16'h66FF, 16'h0000, 16'h0100);
		add_row(rtf65000_pkg::op_moveq, 3'd1, 1, 16'h7001);
		add_row(rtf65000_pkg::op_divu, 3'd1, 1, 16'h80C1);
		add_row(rtf65000_pkg::op_sub, 3'd2, 2, 16'h9078, 16'h1000);
		add_row(rtf65000_pkg::op_illegal, 3'd1, 1, 16'hA000);
		add_row(rtf65000_pkg::op_cmp, 3'd1, 1, 16'hB041);
		add_row(rtf65000_pkg::op_exg, 3'd1, 1, 16'hC141);
		add_row(rtf65000_pkg::op_muls, 3'd1, 1, 16'hC1C1);
		add_row(rtf65000_pkg::op_abcd, 3'd1, 1, 16'hC101);
		add_row(rtf65000_pkg::op_and, 3'd2, 2, 16'hC069, 16'h0002);
		add_row(rtf65000_pkg::op_add, 3'd2, 2, 16'hD0B0, 16'h0004);
		add_row(rtf65000_pkg::op_asdm, 3'd1, 1, 16'hE1D0);
		add_row(rtf65000_pkg::op_lsd, 3'd1, 1, 16'hE248);
		add_row(rtf65000_pkg::op_illegal, 3'd1, 1, 16'hF000);
		// these two fill the queue exactly while hold is high.
		bp_first = row_op.size();
		add_row(rtf65000_pkg::op_move, 3'd5, 5, 16'h33F9, 16'h0000, 16'h1000, 16'h0000, 16'h2000);
		add_row(rtf65000_pkg::op_jsr, 3'd3, 3, 16'h4EB9, 16'h0001, 16'h0000);
	endtask

	task automatic push_rows(input int first, input int last);
		int t;
		rtf65000_pkg::iwin_t w;
		for (int r = first; r < last; r++) begin
			w = row_win[r];
			for (int i = 0; i < row_n[r]; i++) begin
				t = 0;
				while (full === 1'b1 && t < 100) begin
					step();
					t++;
				end
				if (full === 1'b1) begin
					$display("queue stayed full while pushing row %0d", r);
					errors++;
				end else begin
					word = w[16*i +: 16];
					word_strobe = 1'b1;
					step();
					word_strobe = 1'b0;
					random_gap();
				end
			end
		end
	endtask

	task automatic wait_issues(input int target, output logic done);
		int t;
		t = 0;
		while (issued < target && t < 400) begin
			step();
			t++;
		end
		done = (issued >= target);
		if (!done) begin
			$display("timeout with %0d of %0d instructions issued", issued, target);
			errors++;
		end
	endtask

	task automatic wait_full(output logic done);
		int t;
		t = 0;
		while (full !== 1'b1 && t < 50) begin
			step();
			t++;
		end
		done = (full === 1'b1);
		if (!done) begin
			$display("timeout waiting for the queue to report full");
			errors++;
		end
	endtask

	task automatic verify_rows(input int first, input int last);
		int err_before;
		rtf65000_pkg::op_t op;
		rtf65000_pkg::ilen_t len;
		rtf65000_pkg::iwin_t win;
		rtf65000_pkg::iwin_t exp_win;
		rtf65000_pkg::op_t exp_op;
		for (int r = first; r < last; r++) begin
			err_before = errors;
			op = got_op.pop_front();
			len = got_len.pop_front();
			win = got_win.pop_front();
			exp_op = row_op[r];
			exp_win = row_win[r];
			check_op($sformatf("dec_op row %0d", r), op, exp_op);
			check_len($sformatf("dec_len row %0d", r), len, row_len[r]);
			for (int i = 0; i < row_n[r]; i++) begin
				check_word($sformatf("dec_window[%0d] row %0d", i, r), win[16*i +: 16],
					exp_win[16*i +: 16]);
			end
			report_test($sformatf("row %0d %s", r, exp_op.name()), err_before);
		end
	endtask

	initial begin
		rst_n = 1'b0;
		word = '0;
		word_strobe = 1'b0;
		hold = 1'b0;
		lfsr = 32'h6b2b;
		errors = 0;
		tests = 0;
		failed = 0;
		issued = 0;
		build_table();

		e0 = errors;
		repeat (8) begin
			step();
			check_bit("dec_valid", dec_valid, 1'b0);
			check_bit("full", full, 1'b0);
		end
		rst_n = 1'b1;
		repeat (4) begin
			step();
			check_bit("dec_valid", dec_valid, 1'b0);
			check_bit("full", full, 1'b0);
		end
		report_test("reset", e0);

		push_rows(0, bp_first);
		wait_issues(bp_first, ok);
		if (ok) begin
			verify_rows(0, bp_first);
		end else begin
			report_test("stream", -1);
		end

		// the held words must stay queued until hold drops.
		e0 = errors;
		hold = 1'b1;
		push_rows(bp_first, row_op.size());
		wait_full(ok);
		if (issued != bp_first) begin
			$display("instruction issued while hold was high");
			errors++;
		end
		hold = 1'b0;
		wait_issues(row_op.size(), ok);
		report_test("back-pressure", e0);
		if (ok) begin
			verify_rows(bp_first, row_op.size());
		end

		if (decode_unit_inst.decode_unit_chk_inst.fail_count != 0) begin
			$display("%0d assertion failures in the bound checker",
				decode_unit_inst.decode_unit_chk_inst.fail_count);
			errors += decode_unit_inst.decode_unit_chk_inst.fail_count;
		end

		$display("%0d tests, %0d passed, %0d failed, %0d check errors",
			tests, tests - failed, failed, errors);
		if (errors == 0 && failed == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== decode_unit.f ====
+incdir+verilog
verilog/rtf65000_pkg.sv
verilog/idecoder.sv
verilog/ilength.sv
verilog/iqueue.sv
verilog/decode_unit.sv
test/decode_unit_chk.sv
test/decode_unit_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = decode_unit_tb
FILELIST = decode_unit.f
OBJ_DIR  = obj_dir
LOG      = sim.log

BIN  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))
HDRS = $(wildcard verilog/*.svh)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '^TEST PASSED$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
